// File: common/irqc_pkg.sv
/*
 * irqc shared definitions: widths, CSR address map, register and
 * state encodings for the SIMT to scalar interrupt controller
 */
package irqc_pkg;

    localparam int xlen        = 32;
    localparam int num_lanes   = 4;     // thread lanes per CSR bus
    localparam int lane_w      = $clog2(num_lanes);
    localparam int addr_w      = 12;
    localparam int nt_width    = 2;
    localparam int nw_width    = 2;
    localparam int num_threads = 4;
    localparam int num_warps   = 4;
    localparam int num_buses   = 2;     // simt first, scalar last
    localparam int num_regs    = 10;    // bus visible registers

    // ******************************
    // CSR address map
    // ******************************
    localparam logic [addr_w-1:0] csr_s2v   = 12'h7C0;
    localparam logic [addr_w-1:0] csr_v2s   = 12'h7C1;
    localparam logic [addr_w-1:0] csr_tid   = 12'h7C2;
    localparam logic [addr_w-1:0] csr_ipc   = 12'h7C3;
    localparam logic [addr_w-1:0] csr_irq   = 12'h7C4;
    localparam logic [addr_w-1:0] csr_err   = 12'h7C5;
    localparam logic [addr_w-1:0] csr_jalol = 12'h7C6;
    localparam logic [addr_w-1:0] csr_rha   = 12'h7C7;
    localparam logic [addr_w-1:0] csr_rav   = 12'h7C8;
    localparam logic [addr_w-1:0] csr_ravw0 = 12'h7C9;

    typedef enum logic [3:0] {
        reg_s2v,
        reg_v2s,
        reg_tid,
        reg_ipc,
        reg_irq,
        reg_err,
        reg_jalol,
        reg_rha,
        reg_rav,
        reg_ravw0,
        reg_none        // unmapped address
    } irqc_reg_e;

    typedef enum logic [2:0] {
        irqc_idle,
        irqc_wait,
        irqc_pc_swap,
        irqc_wait_isr,
        irqc_revert_warp
    } irqc_state_e;

    // thread id register, seen as a raw word or as warp and thread index
    typedef union packed {
        logic [xlen-1:0] raw;
        struct packed {
            logic [xlen-nw_width-nt_width-1:0] unused;
            logic [nw_width-1:0]               wid;
            logic [nt_width-1:0]               tid;
        } fields;
    } irqc_tid_u;

endpackage

// File: irqc.f
common/irqc_pkg.sv
logic/irqc_bus_port.sv
logic/irqc_regfile.sv
logic/irqc_transfer_fsm.sv
logic/irqc_top.sv
tb/irqc_chk.sv
tb/irqc_tb.sv

// File: logic/irqc_bus_port.sv
/*
 * irqc CSR bus port: address decode, write lane pick and
 * lane replicated read data for one CSR bus
 */
module irqc_bus_port
(
    input  logic                                            read_enable,
    input  logic [irqc_pkg::addr_w-1:0]                     read_addr,
    input  logic                                            write_enable,
    input  logic [irqc_pkg::addr_w-1:0]                     write_addr,
    input  logic [irqc_pkg::num_lanes-1:0]                  write_tmask,
    input  logic [irqc_pkg::num_lanes-1:0][irqc_pkg::xlen-1:0] write_data,
    input  logic [irqc_pkg::xlen-1:0]                       rd_word,
    output logic [irqc_pkg::num_lanes-1:0][irqc_pkg::xlen-1:0] read_data,
    output irqc_pkg::irqc_reg_e                             rd_sel,
    output logic                                            wr_en,
    output irqc_pkg::irqc_reg_e                             wr_sel,
    output logic [irqc_pkg::xlen-1:0]                       wr_word
);

    logic [irqc_pkg::lane_w-1:0] lane;

    function automatic irqc_pkg::irqc_reg_e decode(input logic [irqc_pkg::addr_w-1:0] addr);
        case (addr)
            irqc_pkg::csr_s2v:   decode = irqc_pkg::reg_s2v;
            irqc_pkg::csr_v2s:   decode = irqc_pkg::reg_v2s;
            irqc_pkg::csr_tid:   decode = irqc_pkg::reg_tid;
            irqc_pkg::csr_ipc:   decode = irqc_pkg::reg_ipc;
            irqc_pkg::csr_irq:   decode = irqc_pkg::reg_irq;
            irqc_pkg::csr_err:   decode = irqc_pkg::reg_err;
            irqc_pkg::csr_jalol: decode = irqc_pkg::reg_jalol;
            irqc_pkg::csr_rha:   decode = irqc_pkg::reg_rha;
            irqc_pkg::csr_rav:   decode = irqc_pkg::reg_rav;
            irqc_pkg::csr_ravw0: decode = irqc_pkg::reg_ravw0;
            default:             decode = irqc_pkg::reg_none;
        endcase
    endfunction

    // lowest set lane wins, lane 0 when the mask is empty
    always_comb
    begin
        lane = '0;
        for (int i = irqc_pkg::num_lanes - 1; i >= 0; i--)
        begin
            if (write_tmask[i])
                lane = i[irqc_pkg::lane_w-1:0];
        end
    end

    assign rd_sel  = decode(read_addr);
    assign wr_sel  = decode(write_addr);
    assign wr_en   = write_enable && (wr_sel != irqc_pkg::reg_none);
    assign wr_word = write_data[lane];

    assign read_data = (read_enable && rd_sel != irqc_pkg::reg_none) ?
                       {irqc_pkg::num_lanes{rd_word}} : '0;

endmodule

// File: logic/irqc_regfile.sv
/*
 * irqc register bank: control registers shared by both CSR buses,
 * merged with transfer FSM updates and execute stage responses
 */
module irqc_regfile
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_en   [irqc_pkg::num_buses],
    input  irqc_pkg::irqc_reg_e                wr_sel  [irqc_pkg::num_buses],
    input  logic [irqc_pkg::xlen-1:0]          wr_word [irqc_pkg::num_buses],
    input  irqc_pkg::irqc_reg_e                rd_sel  [irqc_pkg::num_buses],
    output logic [irqc_pkg::xlen-1:0]          rd_word [irqc_pkg::num_buses],
    input  logic                               capture_ctx,
    input  logic                               set_err,
    input  logic                               set_v2s,
    input  logic                               clear_err_v2s,
    input  logic [irqc_pkg::num_threads-1:0]   cur_tmask,
    input  logic [irqc_pkg::num_warps-1:0]     cur_wmask,
    input  logic [irqc_pkg::xlen-1:0]          cur_pc,
    input  logic                               commit_ret_pc_w0,
    input  logic [irqc_pkg::xlen-1:0]          ret_pc_w0,
    input  logic                               commit_ret_pc,
    input  logic [irqc_pkg::xlen-1:0]          ret_pc,
    input  logic                               all_hit,
    output logic                               s2v_set,
    output logic                               s2v_clear,
    output logic [irqc_pkg::xlen-1:0]          irq,
    output logic [irqc_pkg::xlen-1:0]          ipc,
    output logic [irqc_pkg::nw_width-1:0]      wid,
    output logic [irqc_pkg::nt_width-1:0]      tid,
    output logic [irqc_pkg::num_threads-1:0]   load_tmask,
    output logic [irqc_pkg::num_warps-1:0]     load_wmask,
    output logic                               overload_jal,
    output logic [irqc_pkg::xlen-1:0]          ret_handler_addr
);

    logic [irqc_pkg::xlen-1:0]        regs     [irqc_pkg::num_regs];
    logic [irqc_pkg::xlen-1:0]        nxt_regs [irqc_pkg::num_regs];
    logic [irqc_pkg::num_threads-1:0] tmask, nxt_tmask;
    logic [irqc_pkg::num_warps-1:0]   wmask, nxt_wmask;
    irqc_pkg::irqc_tid_u              tid_reg;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < irqc_pkg::num_regs; i++)
                regs[i] <= '0;
            tmask <= '0;
            wmask <= '0;
        end
        else
        begin
            regs  <= nxt_regs;
            tmask <= nxt_tmask;
            wmask <= nxt_wmask;
        end
    end

    // ******************************
    // update merge, later wins
    // ******************************
    always_comb
    begin
        nxt_regs  = regs;
        nxt_tmask = tmask;
        nxt_wmask = wmask;

        for (int b = 0; b < irqc_pkg::num_buses; b++)
        begin
            if (wr_en[b])
                nxt_regs[wr_sel[b]] = wr_word[b];   // scalar bus overrides simt
        end

        if (clear_err_v2s)
        begin
            nxt_regs[irqc_pkg::reg_v2s] = '0;
            nxt_regs[irqc_pkg::reg_err] = '0;
        end
        if (set_v2s)
            nxt_regs[irqc_pkg::reg_v2s] = irqc_pkg::xlen'(1);
        if (set_err)
            nxt_regs[irqc_pkg::reg_err] = irqc_pkg::xlen'(1);
        if (capture_ctx)
        begin
            nxt_regs[irqc_pkg::reg_ipc] = cur_pc;
            nxt_tmask = cur_tmask;
            nxt_wmask = cur_wmask;
        end

        // execute stage responses
        if (commit_ret_pc_w0)
            nxt_regs[irqc_pkg::reg_ravw0] = ret_pc_w0;
        if (commit_ret_pc)
            nxt_regs[irqc_pkg::reg_rav] = ret_pc;
        if (all_hit)
            nxt_regs[irqc_pkg::reg_jalol] = '0;  // every warp is past its jal
    end

    always_comb
    begin
        for (int b = 0; b < irqc_pkg::num_buses; b++)
            rd_word[b] = (rd_sel[b] == irqc_pkg::reg_none) ? '0 : regs[rd_sel[b]];
    end

    assign s2v_set   = regs[irqc_pkg::reg_s2v] == irqc_pkg::xlen'(1);
    assign s2v_clear = regs[irqc_pkg::reg_s2v] == '0;
    assign irq       = regs[irqc_pkg::reg_irq];
    assign ipc       = regs[irqc_pkg::reg_ipc];

    assign tid_reg.raw = regs[irqc_pkg::reg_tid];
    assign wid         = tid_reg.fields.wid;
    assign tid         = tid_reg.fields.tid;

    assign load_tmask       = tmask;
    assign load_wmask       = wmask;
    assign overload_jal     = regs[irqc_pkg::reg_jalol][0];
    assign ret_handler_addr = regs[irqc_pkg::reg_rha];  // link value for overloaded jal

endmodule

// File: logic/irqc_top.sv
/*
 * irqc top: SIMT to scalar interrupt controller with two CSR buses,
 * shared register bank and thread transfer FSM
 */
module irqc_top
(
    input  logic                                            clk,
    input  logic                                            reset,
    // simt CSR bus
    input  logic                                            simt_read_enable,
    input  logic [irqc_pkg::addr_w-1:0]                     simt_read_addr,
    input  logic                                            simt_write_enable,
    input  logic [irqc_pkg::addr_w-1:0]                     simt_write_addr,
    input  logic [irqc_pkg::num_lanes-1:0]                  simt_write_tmask,
    input  logic [irqc_pkg::num_lanes-1:0][irqc_pkg::xlen-1:0] simt_write_data,
    output logic [irqc_pkg::num_lanes-1:0][irqc_pkg::xlen-1:0] simt_read_data,
    // scalar CSR bus
    input  logic                                            scalar_read_enable,
    input  logic [irqc_pkg::addr_w-1:0]                     scalar_read_addr,
    input  logic                                            scalar_write_enable,
    input  logic [irqc_pkg::addr_w-1:0]                     scalar_write_addr,
    input  logic [irqc_pkg::num_lanes-1:0]                  scalar_write_tmask,
    input  logic [irqc_pkg::num_lanes-1:0][irqc_pkg::xlen-1:0] scalar_write_data,
    output logic [irqc_pkg::num_lanes-1:0][irqc_pkg::xlen-1:0] scalar_read_data,
    // thread transfer unit
    input  logic                                            pipeline_drained,
    input  logic                                            thread_found,
    input  logic [irqc_pkg::num_threads-1:0]                cur_tmask,
    input  logic [irqc_pkg::num_warps-1:0]                  cur_wmask,
    input  logic [irqc_pkg::xlen-1:0]                       cur_pc,
    input  logic                                            isr_done,
    output irqc_pkg::irqc_state_e                           state,
    output logic [irqc_pkg::nw_width-1:0]                   wid,
    output logic [irqc_pkg::nt_width-1:0]                   tid,
    output logic [irqc_pkg::num_threads-1:0]                load_tmask,
    output logic [irqc_pkg::xlen-1:0]                       load_pc,
    output logic [irqc_pkg::num_warps-1:0]                  load_wmask,
    // execute stage
    input  logic                                            commit_ret_pc_w0,
    input  logic [irqc_pkg::xlen-1:0]                       ret_pc_w0,
    input  logic                                            commit_ret_pc,
    input  logic [irqc_pkg::xlen-1:0]                       ret_pc,
    input  logic                                            all_hit,
    output logic                                            overload_jal,
    output logic [irqc_pkg::xlen-1:0]                       ret_handler_addr
);

    logic                                   bus_read_enable  [irqc_pkg::num_buses];
    logic [irqc_pkg::addr_w-1:0]            bus_read_addr    [irqc_pkg::num_buses];
    logic                                   bus_write_enable [irqc_pkg::num_buses];
    logic [irqc_pkg::addr_w-1:0]            bus_write_addr   [irqc_pkg::num_buses];
    logic [irqc_pkg::num_lanes-1:0]         bus_write_tmask  [irqc_pkg::num_buses];
    logic [irqc_pkg::num_lanes-1:0][irqc_pkg::xlen-1:0] bus_write_data [irqc_pkg::num_buses];
    logic [irqc_pkg::num_lanes-1:0][irqc_pkg::xlen-1:0] bus_read_data  [irqc_pkg::num_buses];

    logic                                   wr_en   [irqc_pkg::num_buses];
    irqc_pkg::irqc_reg_e                    wr_sel  [irqc_pkg::num_buses];
    logic [irqc_pkg::xlen-1:0]              wr_word [irqc_pkg::num_buses];
    irqc_pkg::irqc_reg_e                    rd_sel  [irqc_pkg::num_buses];
    logic [irqc_pkg::xlen-1:0]              rd_word [irqc_pkg::num_buses];

    logic                                   capture_ctx, set_err, set_v2s, clear_err_v2s;
    logic                                   s2v_set, s2v_clear;
    logic [irqc_pkg::xlen-1:0]              irq, ipc;

    // bus 0 is simt, bus 1 is scalar and wins on a write clash
    assign bus_read_enable  = '{simt_read_enable, scalar_read_enable};
    assign bus_read_addr    = '{simt_read_addr, scalar_read_addr};
    assign bus_write_enable = '{simt_write_enable, scalar_write_enable};
    assign bus_write_addr   = '{simt_write_addr, scalar_write_addr};
    assign bus_write_tmask  = '{simt_write_tmask, scalar_write_tmask};
    assign bus_write_data   = '{simt_write_data, scalar_write_data};
    assign simt_read_data   = bus_read_data[0];
    assign scalar_read_data = bus_read_data[1];

    for (genvar g = 0; g < irqc_pkg::num_buses; g++)
    begin : g_bus
        irqc_bus_port i_port
        (
            .read_enable  (bus_read_enable[g]),
            .read_addr    (bus_read_addr[g]),
            .write_enable (bus_write_enable[g]),
            .write_addr   (bus_write_addr[g]),
            .write_tmask  (bus_write_tmask[g]),
            .write_data   (bus_write_data[g]),
            .rd_word      (rd_word[g]),
            .read_data    (bus_read_data[g]),
            .rd_sel       (rd_sel[g]),
            .wr_en        (wr_en[g]),
            .wr_sel       (wr_sel[g]),
            .wr_word      (wr_word[g])
        );
    end

    irqc_regfile i_regfile
    (
        .clk, .reset,
        .wr_en, .wr_sel, .wr_word, .rd_sel, .rd_word,
        .capture_ctx, .set_err, .set_v2s, .clear_err_v2s,
        .cur_tmask, .cur_wmask, .cur_pc,
        .commit_ret_pc_w0, .ret_pc_w0, .commit_ret_pc, .ret_pc, .all_hit,
        .s2v_set, .s2v_clear, .irq, .ipc, .wid, .tid,
        .load_tmask, .load_wmask, .overload_jal, .ret_handler_addr
    );

    irqc_transfer_fsm i_fsm
    (
        .clk, .reset,
        .s2v_set, .s2v_clear, .pipeline_drained, .thread_found, .isr_done,
        .irq, .ipc, .state,
        .capture_ctx, .set_err, .set_v2s, .clear_err_v2s, .load_pc
    );

endmodule

// File: logic/irqc_transfer_fsm.sv
/*
 * irqc thread transfer FSM: sequences a SIMT to scalar thread move
 * and picks the PC handed to the transfer unit
 */
module irqc_transfer_fsm
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s2v_set,
    input  logic                        s2v_clear,
    input  logic                        pipeline_drained,
    input  logic                        thread_found,
    input  logic                        isr_done,
    input  logic [irqc_pkg::xlen-1:0]   irq,
    input  logic [irqc_pkg::xlen-1:0]   ipc,
    output irqc_pkg::irqc_state_e       state,
    output logic                        capture_ctx,
    output logic                        set_err,
    output logic                        set_v2s,
    output logic                        clear_err_v2s,
    output logic [irqc_pkg::xlen-1:0]   load_pc
);

    irqc_pkg::irqc_state_e next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= irqc_pkg::irqc_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state    = state;
        capture_ctx   = 1'b0;
        set_err       = 1'b0;
        set_v2s       = 1'b0;
        clear_err_v2s = 1'b0;

        case (state)
            irqc_pkg::irqc_idle:
            begin
                clear_err_v2s = s2v_clear;  // scalar side acked
                if (s2v_set)
                    next_state = irqc_pkg::irqc_wait;
            end
            irqc_pkg::irqc_wait:
            begin
                if (pipeline_drained && thread_found)
                begin
                    capture_ctx = 1'b1;
                    next_state  = irqc_pkg::irqc_pc_swap;
                end
                else if (pipeline_drained)
                begin
                    // no thread to move, flag it back to scalar
                    set_err    = 1'b1;
                    set_v2s    = 1'b1;
                    next_state = irqc_pkg::irqc_idle;
                end
            end
            irqc_pkg::irqc_pc_swap:
                next_state = irqc_pkg::irqc_wait_isr;
            irqc_pkg::irqc_wait_isr:
            begin
                if (isr_done)
                    next_state = irqc_pkg::irqc_revert_warp;
            end
            irqc_pkg::irqc_revert_warp:
            begin
                if (s2v_clear)
                begin
                    clear_err_v2s = 1'b1;   // scalar finished loading the thread
                    next_state    = irqc_pkg::irqc_idle;
                end
                else
                    set_v2s = 1'b1;
            end
            default:
                next_state = irqc_pkg::irqc_idle;
        endcase
    end

    assign load_pc = (state == irqc_pkg::irqc_pc_swap) ? irq : ipc;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the irqc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module irqc_tb -f irqc.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Virqc_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$output" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1

// File: tb/irqc_chk.sv
/*
 * irqc checker: concurrent assertions bound to the top level
 */
module irqc_chk
(
    input logic                  clk,
    input logic                  reset,
    input irqc_pkg::irqc_state_e state,
    input logic [31:0]           irq,
    input logic [31:0]           load_pc,
    input logic                  overload_jal
);
    timeunit 1ns;
    timeprecision 1ps;

    state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {irqc_pkg::irqc_idle, irqc_pkg::irqc_wait, irqc_pkg::irqc_pc_swap,
                      irqc_pkg::irqc_wait_isr, irqc_pkg::irqc_revert_warp})
        else $error("state holds an illegal encoding");

    // the transfer unit gets the handler address during the swap
    pc_swap_irq: assert property (@(posedge clk) disable iff (reset)
        state == irqc_pkg::irqc_pc_swap |-> load_pc == irq)
        else $error("load_pc differs from IRQ in pc_swap");

    jal_after_reset: assert property (@(posedge clk) reset |=> !overload_jal)
        else $error("overload_jal set right after reset");

endmodule

bind irqc_top irqc_chk i_chk
(
    .clk          (clk),
    .reset        (reset),
    .state        (state),
    .irq          (irq),
    .load_pc      (load_pc),
    .overload_jal (overload_jal)
);

// File: tb/irqc_tb.sv
/*
 * irqc testbench: drives both CSR buses, the transfer unit and the
 * execute stage, and checks the DUT against a reference model
 */
module irqc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int test_cycles = 300;  // upper bound on the length of all phases

    logic clk;
    logic reset;
    logic simt_read_enable, simt_write_enable, scalar_read_enable, scalar_write_enable;
    logic [11:0] simt_read_addr, simt_write_addr, scalar_read_addr, scalar_write_addr;
    logic [3:0] simt_write_tmask, scalar_write_tmask;
    logic [3:0][31:0] simt_write_data, scalar_write_data, simt_read_data, scalar_read_data;
    logic pipeline_drained, thread_found, isr_done;
    logic [3:0] cur_tmask, cur_wmask, load_tmask, load_wmask;
    logic [31:0] cur_pc, load_pc, ret_pc_w0, ret_pc, ret_handler_addr;
    logic commit_ret_pc_w0, commit_ret_pc, all_hit, overload_jal;
    logic [1:0] wid, tid;
    irqc_pkg::irqc_state_e state;

    int seed = 79;

    // reference model state
    logic [31:0] m_regs [10];
    logic [3:0] m_tmask, m_wmask;
    irqc_pkg::irqc_state_e m_state;

    irqc_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // index into the model registers, -1 for an unmapped address
    function automatic int reg_index(input logic [11:0] addr);
        if (addr >= 12'h7C0 && addr <= 12'h7C9)
            return int'(addr - 12'h7C0);
        return -1;
    endfunction

    function automatic logic [31:0] ref_read(input logic en, input logic [11:0] addr);
        int idx;
        idx = reg_index(addr);
        if (!en || idx < 0)
            return '0;
        return m_regs[idx];
    endfunction

    function automatic logic [31:0] lane_word(input logic [3:0] mask, input logic [3:0][31:0] d);
        for (int i = 0; i < 4; i++)
        begin
            if (mask[i])
                return d[i];
        end
        return d[0];
    endfunction

    function automatic void model_step();
        int idx;
        logic s2v_one, s2v_zero;
        s2v_one  = (m_regs[0] == 32'd1);
        s2v_zero = (m_regs[0] == 32'd0);
        idx = reg_index(simt_write_addr);
        if (simt_write_enable && idx >= 0)
            m_regs[idx] = lane_word(simt_write_tmask, simt_write_data);
        idx = reg_index(scalar_write_addr);
        if (scalar_write_enable && idx >= 0)
            m_regs[idx] = lane_word(scalar_write_tmask, scalar_write_data);
        case (m_state)
            irqc_pkg::irqc_idle:
            begin
                if (s2v_zero)
                begin
                    m_regs[1] = '0;
                    m_regs[5] = '0;
                end
                if (s2v_one)
                    m_state = irqc_pkg::irqc_wait;
            end
            irqc_pkg::irqc_wait:
            begin
                if (pipeline_drained && thread_found)
                begin
                    m_regs[3] = cur_pc;
                    m_tmask   = cur_tmask;
                    m_wmask   = cur_wmask;
                    m_state   = irqc_pkg::irqc_pc_swap;
                end
                else if (pipeline_drained)
                begin
                    m_regs[1] = 32'd1;
                    m_regs[5] = 32'd1;
                    m_state   = irqc_pkg::irqc_idle;
                end
            end
            irqc_pkg::irqc_pc_swap:
                m_state = irqc_pkg::irqc_wait_isr;
            irqc_pkg::irqc_wait_isr:
                if (isr_done)
                    m_state = irqc_pkg::irqc_revert_warp;
            default:
            begin
                if (s2v_zero)
                begin
                    m_regs[1] = '0;
                    m_regs[5] = '0;
                    m_state   = irqc_pkg::irqc_idle;
                end
                else
                    m_regs[1] = 32'd1;
            end
        endcase
        if (commit_ret_pc_w0)
            m_regs[9] = ret_pc_w0;
        if (commit_ret_pc)
            m_regs[8] = ret_pc;
        if (all_hit)
            m_regs[6] = '0;
    endfunction

    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 10; i++)
                m_regs[i] = '0;
            m_tmask = '0;
            m_wmask = '0;
            m_state = irqc_pkg::irqc_idle;
        end
        else
            model_step();
    end

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else
            abort($sformatf("ERROR at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_val(32'(state), 32'(m_state), "state");
            check_val(load_pc, (m_state == irqc_pkg::irqc_pc_swap) ? m_regs[4] : m_regs[3],
                      "load_pc");
            check_val(32'(load_tmask), 32'(m_tmask), "load_tmask");
            check_val(32'(load_wmask), 32'(m_wmask), "load_wmask");
            check_val(32'(overload_jal), 32'(m_regs[6][0]), "overload_jal");
            check_val(ret_handler_addr, m_regs[7], "ret_handler_addr");
            check_val(32'(wid), 32'(m_regs[2][3:2]), "wid");
            check_val(32'(tid), 32'(m_regs[2][1:0]), "tid");
            for (int l = 0; l < 4; l++)
            begin
                check_val(simt_read_data[l], ref_read(simt_read_enable, simt_read_addr),
                          $sformatf("simt read lane %0d", l));
                check_val(scalar_read_data[l], ref_read(scalar_read_enable, scalar_read_addr),
                          $sformatf("scalar read lane %0d", l));
            end
        end
    end

    initial
    begin
        #(2 * test_cycles * 100);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $fatal(1);
    end

    // next cycle, default inputs and random reads
    task automatic step();
        @(posedge clk);
        #10;
        simt_write_enable   = 1'b0;
        scalar_write_enable = 1'b0;
        pipeline_drained    = 1'b0;
        thread_found        = 1'b0;
        isr_done            = 1'b0;
        commit_ret_pc_w0    = 1'b0;
        commit_ret_pc       = 1'b0;
        all_hit             = 1'b0;
        simt_read_enable    = 1'($random(seed));
        scalar_read_enable  = 1'($random(seed));
        simt_read_addr      = 12'h7C0 + 12'($unsigned($random(seed)) % 12);
        scalar_read_addr    = 12'h7C0 + 12'($unsigned($random(seed)) % 12);
        cur_pc              = $random(seed);
        cur_tmask           = 4'($random(seed));
        cur_wmask           = 4'($random(seed));
    endtask

    task automatic write_reg(input int bus, input logic [11:0] addr, input logic [31:0] value);
        step();
        if (bus == 0)
        begin
            simt_write_enable = 1'b1;
            simt_write_addr   = addr;
            simt_write_tmask  = 4'($random(seed));
            simt_write_data   = {4{value}};
        end
        else
        begin
            scalar_write_enable = 1'b1;
            scalar_write_addr   = addr;
            scalar_write_tmask  = 4'($random(seed));
            scalar_write_data   = {4{value}};
        end
    endtask

    task automatic read_reg(input logic [11:0] addr);
        step();
        simt_read_enable = 1'b1;
        simt_read_addr   = addr;
    endtask

    task automatic wait_state(input irqc_pkg::irqc_state_e target);
        for (int i = 0; i < 20; i++)
        begin
            if (state == target)
                return;
            step();
        end
        abort($sformatf("state %s was not reached in time", target.name()));
    endtask

    initial
    begin
        reset = 1'b1;
        {simt_read_enable, simt_write_enable, scalar_read_enable, scalar_write_enable} = '0;
        {simt_read_addr, simt_write_addr, scalar_read_addr, scalar_write_addr} = '0;
        {simt_write_tmask, scalar_write_tmask} = '0;
        simt_write_data = '0;
        scalar_write_data = '0;
        {pipeline_drained, thread_found, isr_done, cur_tmask, cur_wmask, cur_pc} = '0;
        {commit_ret_pc_w0, ret_pc_w0, commit_ret_pc, ret_pc, all_hit} = '0;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        // ******************************
        // register access and priority
        // ******************************
        for (int r = 0; r < 10; r++)
        begin
            for (int b = 0; b < 2; b++)
            begin
                step();
                simt_write_enable   = (b == 0);
                scalar_write_enable = (b == 1);
                simt_write_addr     = 12'h7C0 + 12'(r);
                scalar_write_addr   = 12'h7C0 + 12'(r);
                simt_write_tmask    = 4'($random(seed));
                scalar_write_tmask  = 4'($random(seed));
                for (int l = 0; l < 4; l++)
                begin
                    simt_write_data[l]   = $random(seed);
                    scalar_write_data[l] = $random(seed);
                end
            end
        end
        write_reg(1, irqc_pkg::csr_s2v, 32'd0);
        for (int r = 0; r < 12; r++)
            read_reg(12'h7C0 + 12'(r));
        write_reg(0, irqc_pkg::csr_rha, $random(seed));
        scalar_write_enable = 1'b1;     // same cycle clash on RHA
        scalar_write_addr   = irqc_pkg::csr_rha;
        scalar_write_data   = {4{32'($random(seed))}};
        read_reg(irqc_pkg::csr_rha);

        // ******************************
        // transfers
        // ******************************
        write_reg(0, irqc_pkg::csr_irq, $random(seed));
        write_reg(1, irqc_pkg::csr_s2v, 32'd1);
        wait_state(irqc_pkg::irqc_wait);
        repeat (1 + $unsigned($random(seed)) % 8) step();
        step();
        pipeline_drained = 1'b1;
        thread_found     = 1'b1;
        wait_state(irqc_pkg::irqc_pc_swap);
        wait_state(irqc_pkg::irqc_wait_isr);
        repeat (1 + $unsigned($random(seed)) % 8) step();
        isr_done = 1'b1;
        wait_state(irqc_pkg::irqc_revert_warp);
        read_reg(irqc_pkg::csr_v2s);
        read_reg(irqc_pkg::csr_v2s);
        write_reg(1, irqc_pkg::csr_s2v, 32'd0);
        wait_state(irqc_pkg::irqc_idle);
        read_reg(irqc_pkg::csr_v2s);
        read_reg(irqc_pkg::csr_err);

        // bad thread request, S2V cleared with the drain
        write_reg(1, irqc_pkg::csr_s2v, 32'd1);
        wait_state(irqc_pkg::irqc_wait);
        pipeline_drained    = 1'b1;
        scalar_write_enable = 1'b1;
        scalar_write_addr   = irqc_pkg::csr_s2v;
        scalar_write_data   = '0;
        step();
        simt_read_enable   = 1'b1;  // ERR and V2S flagged for one cycle
        simt_read_addr     = irqc_pkg::csr_err;
        scalar_read_enable = 1'b1;
        scalar_read_addr   = irqc_pkg::csr_v2s;
        read_reg(irqc_pkg::csr_v2s);
        read_reg(irqc_pkg::csr_err);

        // ******************************
        // execute responses and TID
        // ******************************
        write_reg(0, irqc_pkg::csr_rav, $random(seed));
        commit_ret_pc = 1'b1;
        ret_pc        = $random(seed);
        write_reg(1, irqc_pkg::csr_ravw0, $random(seed));
        commit_ret_pc_w0 = 1'b1;
        ret_pc_w0        = $random(seed);
        read_reg(irqc_pkg::csr_rav);
        read_reg(irqc_pkg::csr_ravw0);
        write_reg(0, irqc_pkg::csr_jalol, 32'd1);
        write_reg(1, irqc_pkg::csr_rha, $random(seed));
        step();
        all_hit = 1'b1;
        read_reg(irqc_pkg::csr_jalol);
        for (int i = 0; i < 4; i++)
            write_reg(i % 2, irqc_pkg::csr_tid, $random(seed));
        repeat (2) step();

        $display("Finished with no errors");
        $finish;
    end

endmodule
